// File: verilog.f
+incdir+common
common/core_pkg.sv
decode/decode_unit.sv
decode/control_unit.sv
source/reg_file.sv
source/execute_unit.sv
source/fetch_unit.sv
source/core_top.sv
verif/core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= core_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

# build, run, and succeed only if the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

// File: verif/core_tb.sv
// Core testbench

`timescale 1ns/10ps

`include "core_consts.svh"

module core_tb;

    localparam int MAX_ROWS   = 400;
    localparam int MAX_CYCLES = 1000;

    // one retired instruction and what it must produce
    typedef struct packed {
        core_pkg::inst_t     inst;
        core_pkg::word_t     pc;
        logic                wb_en;
        core_pkg::reg_addr_t rd;
        core_pkg::word_t     value;
    } row_t;

    logic                clock;
    logic                arst_n_i;
    core_pkg::inst_t     imem_data_i;
    core_pkg::word_t     imem_addr_o;
    core_pkg::word_t     pc_o;
    logic                wb_en_o;
    core_pkg::reg_addr_t wb_addr_o;
    core_pkg::word_t     wb_data_o;

    row_t            prog_q[$];
    core_pkg::word_t ref_regs [32];
    core_pkg::word_t ref_pc;
    integer          seed;
    int              checked;

    core_top i_core_top (
        .clock       (clock),
        .arst_n_i    (arst_n_i),
        .imem_addr_o (imem_addr_o),
        .imem_data_i (imem_data_i),
        .pc_o        (pc_o),
        .wb_en_o     (wb_en_o),
        .wb_addr_o   (wb_addr_o),
        .wb_data_o   (wb_data_o)
    );

    always #10 clock = ~clock;

    // --------------------
    // instruction encoders
    // --------------------
    function automatic core_pkg::inst_t itype_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                   input logic [2:0] f3, input logic [4:0] rd,
                                                   input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic core_pkg::inst_t rtype_word(input logic alt, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3,
                                                   input logic [4:0] rd);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic core_pkg::inst_t utype_word(input logic [19:0] imm, input logic [4:0] rd,
                                                   input logic [6:0] opc);
        return {imm, rd, opc};
    endfunction

    function automatic core_pkg::inst_t btype_word(input logic [12:0] off, input logic [4:0] rs2,
                                                   input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic core_pkg::inst_t jtype_word(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // --------------------
    // reference model
    // --------------------
    // rv32i integer result by funct3 and the funct7 alt bit
    function automatic core_pkg::word_t rv_alu(input logic [2:0] f3, input logic alt,
                                               input core_pkg::word_t a, input core_pkg::word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_row(input core_pkg::inst_t inst, input logic writes,
                           input core_pkg::reg_addr_t rd, input core_pkg::word_t value,
                           input core_pkg::word_t next_pc);
        row_t row;
        row.inst  = inst;
        row.pc    = ref_pc;
        row.wb_en = writes && (rd != 5'd0);
        row.rd    = rd;
        row.value = value;
        prog_q.push_back(row);
        if (row.wb_en) begin
            ref_regs[rd] = value;
        end
        ref_pc = next_pc;
    endtask

    task automatic put_lui(input core_pkg::reg_addr_t rd, input logic [19:0] imm);
        add_row(utype_word(imm, rd, 7'b0110111), 1'b1, rd, {imm, 12'h000}, ref_pc + 32'd4);
    endtask

    task automatic put_auipc(input core_pkg::reg_addr_t rd, input logic [19:0] imm);
        add_row(utype_word(imm, rd, 7'b0010111), 1'b1, rd, ref_pc + {imm, 12'h000},
                ref_pc + 32'd4);
    endtask

    task automatic put_opimm(input logic [2:0] f3, input core_pkg::reg_addr_t rd,
                             input core_pkg::reg_addr_t rs1, input logic [11:0] imm);
        core_pkg::word_t imm_sext;
        logic            alt;
        imm_sext = {{20{imm[11]}}, imm};
        // srai carries its funct7 bit inside the immediate
        alt = (f3 == 3'd5) && imm[10];
        add_row(itype_word(imm, rs1, f3, rd, 7'b0010011), 1'b1, rd,
                rv_alu(f3, alt, ref_regs[rs1], imm_sext), ref_pc + 32'd4);
    endtask

    task automatic put_op(input logic [2:0] f3, input logic alt, input core_pkg::reg_addr_t rd,
                          input core_pkg::reg_addr_t rs1, input core_pkg::reg_addr_t rs2);
        add_row(rtype_word(alt, rs2, rs1, f3, rd), 1'b1, rd,
                rv_alu(f3, alt, ref_regs[rs1], ref_regs[rs2]), ref_pc + 32'd4);
    endtask

    task automatic put_branch(input logic [2:0] f3, input core_pkg::reg_addr_t rs1,
                              input core_pkg::reg_addr_t rs2, input logic [12:0] off);
        core_pkg::word_t a;
        core_pkg::word_t b;
        logic            taken;
        a = ref_regs[rs1];
        b = ref_regs[rs2];
        case (f3)
            3'd0:    taken = (a == b);
            3'd1:    taken = (a != b);
            3'd4:    taken = ($signed(a) < $signed(b));
            3'd5:    taken = !($signed(a) < $signed(b));
            3'd6:    taken = (a < b);
            default: taken = !(a < b);
        endcase
        add_row(btype_word(off, rs2, rs1, f3), 1'b0, 5'd0, 32'd0,
                taken ? ref_pc + {{19{off[12]}}, off} : ref_pc + 32'd4);
    endtask

    task automatic put_jal(input core_pkg::reg_addr_t rd, input logic [20:0] off);
        add_row(jtype_word(off, rd), 1'b1, rd, ref_pc + 32'd4, ref_pc + {{11{off[20]}}, off});
    endtask

    task automatic put_jalr(input core_pkg::reg_addr_t rd, input core_pkg::reg_addr_t rs1,
                            input logic [11:0] imm);
        core_pkg::word_t target;
        target    = ref_regs[rs1] + {{20{imm[11]}}, imm};
        target[0] = 1'b0;
        add_row(itype_word(imm, rs1, 3'd0, rd, 7'b1100111), 1'b1, rd, ref_pc + 32'd4, target);
    endtask

    // lui plus addi with the upper part rounded for the signed low half
    task automatic load_reg(input core_pkg::reg_addr_t rd, input core_pkg::word_t value);
        core_pkg::word_t sum;
        sum = value + 32'h0000_0800;
        put_lui(rd, sum[31:12]);
        put_opimm(3'd0, rd, rd, value[11:0]);
    endtask

    // --------------------
    // program
    // --------------------
    task automatic build_program();
        core_pkg::word_t ra;
        core_pkg::word_t rb;
        core_pkg::word_t rc;
        logic [11:0]     imm;
        logic [12:0]     offs [3];
        logic [2:0]      br_f3 [6];
        ra      = $random(seed);
        rb      = $random(seed);
        rc      = $random(seed);
        imm     = rc[11:0];
        offs    = '{13'h0008, 13'h1ff4, 13'h0010};
        br_f3   = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};

        put_lui(5'd1, 20'habcde);
        load_reg(5'd2, ra);
        load_reg(5'd3, rb);
        // x4 negative and x5 positive, so signed and unsigned order disagree
        load_reg(5'd4, ra | 32'h8000_0000);
        load_reg(5'd5, rb & 32'h7fff_ffff);

        put_opimm(3'd0, 5'd6, 5'd2, imm);
        put_op(3'd0, 1'b0, 5'd7, 5'd2, 5'd3);
        put_op(3'd0, 1'b1, 5'd8, 5'd2, 5'd3);
        put_op(3'd7, 1'b0, 5'd9, 5'd2, 5'd3);
        put_op(3'd6, 1'b0, 5'd10, 5'd2, 5'd3);
        put_op(3'd4, 1'b0, 5'd11, 5'd2, 5'd3);
        put_op(3'd2, 1'b0, 5'd12, 5'd4, 5'd5);
        put_op(3'd3, 1'b0, 5'd13, 5'd4, 5'd5);
        put_op(3'd2, 1'b0, 5'd14, 5'd5, 5'd4);
        put_op(3'd3, 1'b0, 5'd15, 5'd5, 5'd4);
        put_op(3'd1, 1'b0, 5'd16, 5'd2, 5'd3);
        put_op(3'd5, 1'b0, 5'd17, 5'd4, 5'd3);
        put_op(3'd5, 1'b1, 5'd18, 5'd4, 5'd3);
        put_opimm(3'd1, 5'd19, 5'd2, 12'h007);
        put_opimm(3'd5, 5'd20, 5'd4, 12'h40d);
        put_opimm(3'd5, 5'd21, 5'd4, 12'h00d);
        put_opimm(3'd2, 5'd22, 5'd4, imm);
        put_opimm(3'd3, 5'd23, 5'd4, imm);
        put_opimm(3'd4, 5'd24, 5'd2, imm);
        put_opimm(3'd6, 5'd25, 5'd2, imm);
        put_opimm(3'd7, 5'd26, 5'd2, imm);

        // x0 stays zero
        put_opimm(3'd0, 5'd0, 5'd2, 12'h055);
        put_op(3'd0, 1'b0, 5'd24, 5'd0, 5'd2);
        put_op(3'd0, 1'b0, 5'd25, 5'd0, 5'd0);

        // every branch kind on lt, gt and equal operands
        for (int n = 0; n < 6; n++) begin
            put_branch(br_f3[n], 5'd4, 5'd5, offs[0]);
            put_branch(br_f3[n], 5'd5, 5'd4, offs[1]);
            put_branch(br_f3[n], 5'd2, 5'd2, offs[2]);
        end

        put_jal(5'd26, 21'h00018);
        load_reg(5'd27, 32'h0000_0401);
        // odd sum so the target needs bit 0 cleared
        put_jalr(5'd28, 5'd27, 12'h008);
        put_auipc(5'd29, ra[19:0]);
        put_jal(5'd0, 21'h1ffff8);
        put_op(3'd0, 1'b0, 5'd30, 5'd26, 5'd28);
        // custom-0 opcode acts as a no-op
        add_row(32'h0000_000b, 1'b0, 5'd0, 32'd0, ref_pc + 32'd4);
    endtask

    task automatic check_value(input string name, input core_pkg::word_t got,
                               input core_pkg::word_t exp);
        if (got !== exp) begin
            $display("[FAIL] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("*** FAILED ***");
            $fatal(1);
        end
    endtask

    // --------------------
    // stimulus and checking
    // --------------------
    initial begin
        row_t row;
        clock       = 1'b0;
        arst_n_i    = 1'b0;
        imem_data_i = '0;
        seed        = 43;
        checked     = 0;
        ref_pc      = `RESET_PC;
        for (int r = 0; r < 32; r++) begin
            ref_regs[r] = '0;
        end
        build_program();

        repeat (10) @(posedge clock);
        #2;
        arst_n_i = 1'b1;

        for (int i = 0; i < prog_q.size() && i < MAX_ROWS; i++) begin
            row         = prog_q[i];
            imem_data_i = row.inst;
            // sample just before the next rising edge
            #16;
            check_value($sformatf("pc_o row %0d", i), pc_o, row.pc);
            check_value($sformatf("imem_addr_o row %0d", i), imem_addr_o, row.pc);
            check_value($sformatf("wb_en_o row %0d", i), {31'b0, wb_en_o}, {31'b0, row.wb_en});
            if (row.wb_en) begin
                check_value($sformatf("wb_addr_o row %0d", i), {27'b0, wb_addr_o},
                            {27'b0, row.rd});
                check_value($sformatf("wb_data_o row %0d", i), wb_data_o, row.value);
            end
            checked++;
            @(posedge clock);
            #2;
        end

        if (checked > 0 && checked == prog_q.size()) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("only %0d of %0d program rows were checked", checked, prog_q.size());
            $display("*** FAILED ***");
            $fatal(1);
        end
    end

    // watchdog
    initial begin
        for (int c = 0; c < MAX_CYCLES; c++) begin
            @(posedge clock);
        end
        $display("simulation ran for %0d clock cycles without completing", MAX_CYCLES);
        $display("*** FAILED ***");
        $fatal(1);
    end

endmodule

// File: source/core_top.sv
// Single-cycle RV32I core top

`timescale 1ns/10ps

module core_top (
    input  logic                clock,
    input  logic                arst_n_i,
    // instruction port
    output core_pkg::word_t     imem_addr_o,
    input  core_pkg::inst_t     imem_data_i,
    // retire status
    output core_pkg::word_t     pc_o,
    output logic                wb_en_o,
    output core_pkg::reg_addr_t wb_addr_o,
    output core_pkg::word_t     wb_data_o
);

    core_pkg::word_t     pc;
    core_pkg::reg_addr_t rs1_addr;
    core_pkg::reg_addr_t rs2_addr;
    core_pkg::reg_addr_t rd_addr;
    core_pkg::word_t     rs1_data;
    core_pkg::word_t     rs2_data;
    core_pkg::word_t     op1;
    core_pkg::word_t     op2;
    core_pkg::word_t     jalr_target;
    core_pkg::word_t     br_target;
    core_pkg::word_t     jal_target;
    logic                br_eq;
    logic                br_lt;
    logic                br_ltu;
    core_pkg::ctrl_t     ctrl;
    core_pkg::pc_sel_t   pc_sel;
    core_pkg::word_t     wb_data;
    logic                wb_en;

    // --------------------
    // datapath
    // --------------------
    fetch_unit i_fetch_unit (
        .clock         (clock),
        .arst_n_i      (arst_n_i),
        .pc_sel_i      (pc_sel),
        .br_target_i   (br_target),
        .jal_target_i  (jal_target),
        .jalr_target_i (jalr_target),
        .pc_o          (pc)
    );

    decode_unit i_decode_unit (
        .inst_i        (imem_data_i),
        .pc_i          (pc),
        .ctrl_i        (ctrl),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rd_addr_o     (rd_addr),
        .op1_o         (op1),
        .op2_o         (op2),
        .jalr_target_o (jalr_target),
        .br_target_o   (br_target),
        .jal_target_o  (jal_target),
        .br_eq_o       (br_eq),
        .br_lt_o       (br_lt),
        .br_ltu_o      (br_ltu)
    );

    control_unit i_control_unit (
        .inst_i   (imem_data_i),
        .br_eq_i  (br_eq),
        .br_lt_i  (br_lt),
        .br_ltu_i (br_ltu),
        .ctrl_o   (ctrl),
        .pc_sel_o (pc_sel)
    );

    reg_file i_reg_file (
        .clock      (clock),
        .arst_n_i   (arst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wr_en_i    (wb_en),
        .wr_addr_i  (rd_addr),
        .wr_data_i  (wb_data)
    );

    execute_unit i_execute_unit (
        .op1_i     (op1),
        .op2_i     (op2),
        .pc_i      (pc),
        .ctrl_i    (ctrl),
        .wb_data_o (wb_data)
    );

    // writes to x0 are not reported
    assign wb_en       = ctrl.wb_en && (rd_addr != '0);
    assign imem_addr_o = pc;
    assign pc_o        = pc;
    assign wb_en_o     = wb_en;
    assign wb_addr_o   = rd_addr;
    assign wb_data_o   = wb_data;

endmodule

// File: source/fetch_unit.sv
// Program counter and fetch

`timescale 1ns/10ps

`include "core_consts.svh"

module fetch_unit (
    input  logic              clock,
    input  logic              arst_n_i,
    input  core_pkg::pc_sel_t pc_sel_i,
    input  core_pkg::word_t   br_target_i,
    input  core_pkg::word_t   jal_target_i,
    input  core_pkg::word_t   jalr_target_i,
    output core_pkg::word_t   pc_o
);

    core_pkg::word_t pc_q;
    core_pkg::word_t pc_next;

    // --------------------
    // next pc
    // --------------------
    always_comb begin
        case (pc_sel_i)
            core_pkg::PC_BRANCH: pc_next = br_target_i;
            core_pkg::PC_JAL:    pc_next = jal_target_i;
            core_pkg::PC_JALR:   pc_next = jalr_target_i;
            default:             pc_next = pc_q + 32'd4;
        endcase
    end

    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o = pc_q;

endmodule

// File: source/execute_unit.sv
// Integer execute unit

`timescale 1ns/10ps

module execute_unit (
    input  core_pkg::word_t op1_i,
    input  core_pkg::word_t op2_i,
    input  core_pkg::word_t pc_i,
    input  core_pkg::ctrl_t ctrl_i,
    output core_pkg::word_t wb_data_o
);

    core_pkg::word_t alu_result;
    core_pkg::word_t pc_plus4;
    logic [4:0]      shamt;

    assign shamt    = op2_i[4:0];
    assign pc_plus4 = pc_i + 32'd4;

    // --------------------
    // alu
    // --------------------
    always_comb begin
        case (ctrl_i.alu_op)
            core_pkg::ALU_ADD:   alu_result = op1_i + op2_i;
            core_pkg::ALU_SUB:   alu_result = op1_i - op2_i;
            core_pkg::ALU_AND:   alu_result = op1_i & op2_i;
            core_pkg::ALU_OR:    alu_result = op1_i | op2_i;
            core_pkg::ALU_XOR:   alu_result = op1_i ^ op2_i;
            core_pkg::ALU_SLT: begin
                alu_result = {31'b0, $signed(op1_i) < $signed(op2_i)};
            end
            core_pkg::ALU_SLTU: begin
                alu_result = {31'b0, op1_i < op2_i};
            end
            core_pkg::ALU_SLL:   alu_result = op1_i << shamt;
            core_pkg::ALU_SRL:   alu_result = op1_i >> shamt;
            core_pkg::ALU_SRA:   alu_result = $signed(op1_i) >>> shamt;
            // lui result passes straight through
            core_pkg::ALU_COPY1: alu_result = op1_i;
            default:             alu_result = '0;
        endcase
    end

    // --------------------
    // writeback select
    // --------------------
    // link value for jal and jalr
    assign wb_data_o = (ctrl_i.wb_sel == core_pkg::WB_PC4) ? pc_plus4 : alu_result;

endmodule

// File: source/reg_file.sv
// Integer register file

`timescale 1ns/10ps

module reg_file (
    input  logic                clock,
    input  logic                arst_n_i,
    // read ports
    input  core_pkg::reg_addr_t rs1_addr_i,
    input  core_pkg::reg_addr_t rs2_addr_i,
    output core_pkg::word_t     rs1_data_o,
    output core_pkg::word_t     rs2_data_o,
    // write port
    input  logic                wr_en_i,
    input  core_pkg::reg_addr_t wr_addr_i,
    input  core_pkg::word_t     wr_data_i
);

    core_pkg::word_t regs [32];

    // --------------------
    // write port
    // --------------------
    always_ff @(posedge clock or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en_i && wr_addr_i != '0) begin
            regs[wr_addr_i] <= wr_data_i;
        end
    end

    // x0 is hardwired
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule

// File: decode/control_unit.sv
// Instruction control decoder

`timescale 1ns/10ps

module control_unit (
    input  core_pkg::inst_t   inst_i,
    input  logic              br_eq_i,
    input  logic              br_lt_i,
    input  logic              br_ltu_i,
    output core_pkg::ctrl_t   ctrl_o,
    output core_pkg::pc_sel_t pc_sel_o
);

    // rv32i major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;

    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              funct7_b5;
    logic              br_taken;
    core_pkg::alu_op_t alu_func;

    assign opcode    = inst_i[6:0];
    assign funct3    = inst_i[14:12];
    assign funct7_b5 = inst_i[30];

    // --------------------
    // branch condition
    // --------------------
    // odd funct3 inverts the test
    always_comb begin
        case (funct3[2:1])
            2'b00:   br_taken = br_eq_i ^ funct3[0];
            2'b10:   br_taken = br_lt_i ^ funct3[0];
            2'b11:   br_taken = br_ltu_i ^ funct3[0];
            default: br_taken = 1'b0;
        endcase
    end

    // --------------------
    // alu function
    // --------------------
    // sub only exists in register form, shifts use bit 30 in both
    always_comb begin
        case (funct3)
            3'b000: begin
                if (opcode == OPC_OP && funct7_b5) begin
                    alu_func = core_pkg::ALU_SUB;
                end else begin
                    alu_func = core_pkg::ALU_ADD;
                end
            end
            3'b001:  alu_func = core_pkg::ALU_SLL;
            3'b010:  alu_func = core_pkg::ALU_SLT;
            3'b011:  alu_func = core_pkg::ALU_SLTU;
            3'b100:  alu_func = core_pkg::ALU_XOR;
            3'b101:  alu_func = funct7_b5 ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
            3'b110:  alu_func = core_pkg::ALU_OR;
            default: alu_func = core_pkg::ALU_AND;
        endcase
    end

    // --------------------
    // main decode
    // --------------------
    always_comb begin
        // unknown opcodes fall through as a no-op
        ctrl_o.op1_sel = core_pkg::OP1_RS1;
        ctrl_o.op2_sel = core_pkg::OP2_RS2;
        ctrl_o.alu_op  = core_pkg::ALU_ADD;
        ctrl_o.wb_sel  = core_pkg::WB_ALU;
        ctrl_o.wb_en   = 1'b0;
        pc_sel_o       = core_pkg::PC_PLUS4;

        case (opcode)
            OPC_LUI: begin
                ctrl_o.op1_sel = core_pkg::OP1_UIMM;
                ctrl_o.alu_op  = core_pkg::ALU_COPY1;
                ctrl_o.wb_en   = 1'b1;
            end
            OPC_AUIPC: begin
                ctrl_o.op1_sel = core_pkg::OP1_UIMM;
                ctrl_o.op2_sel = core_pkg::OP2_PC;
                ctrl_o.wb_en   = 1'b1;
            end
            OPC_JAL: begin
                ctrl_o.wb_sel = core_pkg::WB_PC4;
                ctrl_o.wb_en  = 1'b1;
                pc_sel_o      = core_pkg::PC_JAL;
            end
            OPC_JALR: begin
                ctrl_o.wb_sel = core_pkg::WB_PC4;
                ctrl_o.wb_en  = 1'b1;
                pc_sel_o      = core_pkg::PC_JALR;
            end
            OPC_BRANCH: begin
                pc_sel_o = br_taken ? core_pkg::PC_BRANCH : core_pkg::PC_PLUS4;
            end
            OPC_OP_IMM: begin
                ctrl_o.op2_sel = core_pkg::OP2_IIMM;
                ctrl_o.alu_op  = alu_func;
                ctrl_o.wb_en   = 1'b1;
            end
            OPC_OP: begin
                ctrl_o.alu_op = alu_func;
                ctrl_o.wb_en  = 1'b1;
            end
            default: begin
                ctrl_o.wb_en = 1'b0;
            end
        endcase
    end

endmodule

// File: decode/decode_unit.sv
// Instruction decode unit

`timescale 1ns/10ps

module decode_unit (
    // instruction and its pc
    input  core_pkg::inst_t     inst_i,
    input  core_pkg::word_t     pc_i,
    input  core_pkg::ctrl_t     ctrl_i,
    // register file access
    input  core_pkg::word_t     rs1_data_i,
    input  core_pkg::word_t     rs2_data_i,
    output core_pkg::reg_addr_t rs1_addr_o,
    output core_pkg::reg_addr_t rs2_addr_o,
    output core_pkg::reg_addr_t rd_addr_o,
    // operands
    output core_pkg::word_t     op1_o,
    output core_pkg::word_t     op2_o,
    // jump targets
    output core_pkg::word_t     jalr_target_o,
    output core_pkg::word_t     br_target_o,
    output core_pkg::word_t     jal_target_o,
    // branch compare flags
    output logic                br_eq_o,
    output logic                br_lt_o,
    output logic                br_ltu_o
);

    core_pkg::word_t imm_i_sext;
    core_pkg::word_t imm_s_sext;
    core_pkg::word_t imm_b_sext;
    core_pkg::word_t imm_u_sext;
    core_pkg::word_t imm_j_sext;
    core_pkg::word_t jalr_sum;

    // --------------------
    // register fields
    // --------------------
    assign rd_addr_o  = inst_i[11:7];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    // --------------------
    // immediates
    // --------------------
    assign imm_i_sext = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_s_sext = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};

    // branch offset is signed so backward branches reach lower pcs
    assign imm_b_sext = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};

    assign imm_u_sext = {inst_i[31:12], 12'b0};
    assign imm_j_sext = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};

    // --------------------
    // jump targets
    // --------------------
    assign jalr_sum      = rs1_data_i + imm_i_sext;
    // jalr drops the lowest bit
    assign jalr_target_o = {jalr_sum[31:1], 1'b0};
    assign br_target_o   = pc_i + imm_b_sext;
    assign jal_target_o  = pc_i + imm_j_sext;

    // --------------------
    // branch flags
    // --------------------
    assign br_eq_o  = (rs1_data_i == rs2_data_i);
    assign br_lt_o  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_ltu_o = (rs1_data_i < rs2_data_i);

    // --------------------
    // operand muxes
    // --------------------
    assign op1_o = (ctrl_i.op1_sel == core_pkg::OP1_RS1) ? rs1_data_i : imm_u_sext;

    always_comb begin
        case (ctrl_i.op2_sel)
            core_pkg::OP2_PC:   op2_o = pc_i;
            core_pkg::OP2_IIMM: op2_o = imm_i_sext;
            // kept for store format, nothing selects it yet
            core_pkg::OP2_SIMM: op2_o = imm_s_sext;
            default:            op2_o = rs2_data_i;
        endcase
    end

endmodule

// File: common/core_pkg.sv
// Core shared types

package core_pkg;

`include "core_consts.svh"

    // --------------------
    // vector types
    // --------------------
    typedef logic [`DATA_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`INST_WIDTH-1:0]     inst_t;

    // --------------------
    // control encodings
    // --------------------

    // op1 source, bit set means register operand
    typedef enum logic {
        OP1_UIMM = 1'b0,
        OP1_RS1  = 1'b1
    } op1_sel_t;

    typedef enum logic [1:0] {
        OP2_PC   = 2'b00,
        OP2_IIMM = 2'b01,
        OP2_SIMM = 2'b10,
        OP2_RS2  = 2'b11
    } op2_sel_t;

    typedef enum logic [3:0] {
        ALU_ADD   = 4'd0,
        ALU_SUB   = 4'd1,
        ALU_AND   = 4'd2,
        ALU_OR    = 4'd3,
        ALU_XOR   = 4'd4,
        ALU_SLT   = 4'd5,
        ALU_SLTU  = 4'd6,
        ALU_SLL   = 4'd7,
        ALU_SRL   = 4'd8,
        ALU_SRA   = 4'd9,
        ALU_COPY1 = 4'd10
    } alu_op_t;

    typedef enum logic [1:0] {
        PC_PLUS4  = 2'b00,
        PC_BRANCH = 2'b01,
        PC_JAL    = 2'b10,
        PC_JALR   = 2'b11
    } pc_sel_t;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_PC4 = 1'b1
    } wb_sel_t;

    // per-instruction control bundle
    typedef struct packed {
        op1_sel_t op1_sel;
        op2_sel_t op2_sel;
        alu_op_t  alu_op;
        wb_sel_t  wb_sel;
        logic     wb_en;
    } ctrl_t;

endpackage

// File: common/core_consts.svh
// Core width and reset constants

`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// --------------------
// datapath widths
// --------------------

// registers and pc
`define DATA_WIDTH 32

// register index, x0 to x31
`define REG_ADDR_WIDTH 5

// one instruction word
`define INST_WIDTH 32

// --------------------
// reset state
// --------------------

// first fetch address
`define RESET_PC 32'h0000_0000

`endif
